//--- include/ads124x_macros.svh
// ========================================
// ADS124x controller constants
// Register map, ADC command bytes, SPI and FIFO sizing
// ========================================
`ifndef ADS124X_MACROS_SVH
`define ADS124X_MACROS_SVH

// APB register byte offsets
`define ADS_REG_CTRL    5'h00
`define ADS_REG_PERIOD  5'h04
`define ADS_REG_TXDATA  5'h08
`define ADS_REG_CMD     5'h0C
`define ADS_REG_STATUS  5'h10
`define ADS_REG_RXDATA  5'h14
`define ADS_REG_FIFO    5'h18

// ADC command bytes
`define ADS_WREG_MUX0   16'h4000
`define ADS_NOOP        8'hFF

// MUX0 codes for AIN3-AIN2, AIN2-AIN1, AIN1-AIN0
`define ADS_MUX_CH0     8'h1A
`define ADS_MUX_CH1     8'h11
`define ADS_MUX_CH2     8'h08

`define ADS_SPI_DIV     2
`define ADS_FIFO_DEPTH  8

`endif

//--- hdl/ads124x_pkg.sv
// ========================================
// ADS124x controller types
// Sample word and SPI transfer length
// ========================================
`default_nettype none

package ads124x_pkg;

    // Bytes per transfer minus one
    typedef logic [1:0] spi_len_t;

    typedef struct packed {
        logic [7:0]  tag;
        logic [23:0] code;
    } ads_sample_t;

    // Raw SPI receive word or channel-tagged conversion
    typedef union packed {
        logic [31:0] raw;
        ads_sample_t sample;
    } ads_word_u;

endpackage

`default_nettype wire

//--- hdl/ads124x_apb_regs.sv
// ========================================
// ADS124x APB register block
// Control, period, manual command, status,
// receive word and FIFO read port
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module ads124x_apb_regs import ads124x_pkg::*; (
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            psel,
    input  wire            penable,
    input  wire            pwrite,
    input  wire [4:0]      paddr,
    input  wire [31:0]     pwdata,
    output logic [31:0]    prdata,
    output wire            pready,
    output wire            pslverr,
    output wire            auto_mode,
    output wire            start_pin,
    output wire            reset_pin_n,
    output logic [31:0]    period,
    output logic [31:0]    tx_word,
    output wire            cmd_go,
    output spi_len_t       cmd_len,
    output wire            ovf_clear,
    output wire            pop,
    input  wire            busy,
    input  wire            rx_done,
    input  wire ads_word_u rx_word,
    input  wire            drdy_level,
    input  wire            overflow,
    input  wire [3:0]      fifo_level,
    input  wire ads_word_u fifo_head,
    input  wire            fifo_empty
);

    logic [2:0] ctrl;
    logic       rx_valid;
    ads_word_u  rx_data;
    logic       wr_en;
    logic       rd_en;
    logic       addr_ok;

    assign wr_en  = psel && penable && pwrite;
    assign rd_en  = psel && penable && !pwrite;
    assign pready = 1'b1;

    assign auto_mode   = ctrl[0];
    assign start_pin   = ctrl[1];
    assign reset_pin_n = ctrl[2];

    // Manual transfer only when the request path is free
    assign cmd_go    = wr_en && paddr == `ADS_REG_CMD && !auto_mode && !busy;
    assign cmd_len   = pwdata[1:0];
    assign ovf_clear = wr_en && paddr == `ADS_REG_STATUS && pwdata[3];
    assign pop       = rd_en && paddr == `ADS_REG_FIFO && !fifo_empty;

    always_comb begin
        addr_ok = 1'b1;
        case (paddr)
            `ADS_REG_CTRL:   prdata = {29'd0, ctrl};
            `ADS_REG_PERIOD: prdata = period;
            `ADS_REG_TXDATA: prdata = tx_word;
            `ADS_REG_CMD:    prdata = '0;
            `ADS_REG_STATUS: prdata = {24'd0, fifo_level, overflow, drdy_level, rx_valid, busy};
            `ADS_REG_RXDATA: prdata = rx_data.raw;
            `ADS_REG_FIFO:   prdata = fifo_head.raw;
            default: begin
                prdata  = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    assign pslverr = psel && penable &&
                     (!addr_ok || (rd_en && paddr == `ADS_REG_FIFO && fifo_empty));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl    <= 3'b100;
            period  <= 32'd1000;
            tx_word <= '0;
        end else if (wr_en) begin
            case (paddr)
                `ADS_REG_CTRL:   ctrl    <= pwdata[2:0];
                `ADS_REG_PERIOD: period  <= pwdata;
                `ADS_REG_TXDATA: tx_word <= pwdata;
                default: ;
            endcase
        end
    end

    // Last manual receive word
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rx_valid <= 1'b0;
            rx_data  <= '0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
            rx_data  <= rx_word;
        end else if (cmd_go) begin
            rx_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ads124x_seq_ctrl.sv
// ========================================
// ADS124x sequence controller
// Sample period timing, DRDY handling, auto channel
// sequencing and manual request forwarding
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module ads124x_seq_ctrl import ads124x_pkg::*; (
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            auto_mode,
    input  wire            start_pin,
    input  wire            reset_pin_n,
    input  wire [31:0]     period,
    input  wire [31:0]     tx_word,
    input  wire            cmd_go,
    input  wire spi_len_t  cmd_len,
    input  wire            drdy,
    input  wire            pps,
    input  wire            req_ready,
    input  wire            done,
    input  wire ads_word_u rx_word,
    output wire            start,
    output wire            ads_reset_n,
    output wire            drdy_level,
    output wire            busy,
    output logic           req_valid,
    output logic [31:0]    req_data,
    output spi_len_t       req_len,
    output wire            rx_done,
    output logic           push,
    output ads_word_u      push_word
);

    typedef enum logic [1:0] {S_IDLE, S_MUX, S_WAIT, S_READ} state_t;

    state_t      state;
    logic [1:0]  ch;
    logic [31:0] counter;
    logic [31:0] third;
    logic [32:0] two_thirds;
    logic        tick0;
    logic        tick1;
    logic        tick2;
    logic        tick_sel;
    logic [7:0]  mux_code;
    logic        drdy_meta;
    logic        drdy_sync;
    logic        drdy_q;
    logic        drdy_fall;
    logic        man_busy;
    logic        go_mux;
    logic        go_read;

    // Period counter and slot ticks
    // ========================================
    assign third      = period / 32'd3;
    assign two_thirds = {period, 1'b0} / 33'd3;

    always_ff @(posedge aclk) begin
        if (!aresetn || pps) begin
            counter <= '1;
        end else if (counter == period - 32'd1) begin
            counter <= '0;
        end else begin
            counter <= counter + 32'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tick0 <= 1'b0;
            tick1 <= 1'b0;
            tick2 <= 1'b0;
        end else begin
            tick0 <= counter == 32'd1;
            tick1 <= counter == third + 32'd1;
            tick2 <= counter == two_thirds[31:0] + 32'd1;
        end
    end

    // DRDY synchronizer, idles high
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            {drdy_meta, drdy_sync, drdy_q} <= 3'b111;
        end else begin
            drdy_meta <= drdy;
            drdy_sync <= drdy_meta;
            drdy_q    <= drdy_sync;
        end
    end

    assign drdy_fall  = drdy_q && !drdy_sync;
    assign drdy_level = drdy_sync;

    // Auto channel sequencer
    // ========================================
    always_comb begin
        case (ch)
            2'd0: begin
                tick_sel = tick0;
                mux_code = `ADS_MUX_CH0;
            end
            2'd1: begin
                tick_sel = tick1;
                mux_code = `ADS_MUX_CH1;
            end
            default: begin
                tick_sel = tick2;
                mux_code = `ADS_MUX_CH2;
            end
        endcase
    end

    assign go_mux  = state == S_IDLE && auto_mode && !man_busy && tick_sel;
    assign go_read = state == S_WAIT && drdy_fall;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= S_IDLE;
            ch    <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!auto_mode) begin
                        ch <= 2'd0;
                    end else if (go_mux) begin
                        state <= S_MUX;
                    end
                end
                S_MUX: begin
                    if (done) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (go_read) begin
                        state <= S_READ;
                    end else if (!auto_mode) begin
                        state <= S_IDLE;
                    end
                end
                S_READ: begin
                    if (done) begin
                        state <= S_IDLE;
                        ch    <= (ch == 2'd2) ? 2'd0 : ch + 2'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request channel to the framer
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            req_valid <= 1'b0;
        end else if (go_mux || go_read || cmd_go) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (go_mux) begin
            req_data <= {8'h00, `ADS_WREG_MUX0, mux_code};
            req_len  <= 2'd2;
        end else if (go_read) begin
            req_data <= {8'h00, {3{`ADS_NOOP}}};
            req_len  <= 2'd2;
        end else if (cmd_go) begin
            req_data <= tx_word;
            req_len  <= cmd_len;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            man_busy <= 1'b0;
        end else if (cmd_go) begin
            man_busy <= 1'b1;
        end else if (done) begin
            man_busy <= 1'b0;
        end
    end

    assign rx_done = man_busy && done;
    // Also busy while a sequence drains after auto mode is left
    assign busy    = man_busy || (!auto_mode && state != S_IDLE);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            push <= 1'b0;
        end else begin
            push <= state == S_READ && done && auto_mode;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_READ && done) begin
            push_word.sample.tag  <= {6'd0, ch};
            push_word.sample.code <= rx_word.sample.code;
        end
    end

    assign start       = auto_mode || start_pin;
    assign ads_reset_n = auto_mode || reset_pin_n;

    // Samples come from auto reads, never from a manual transfer
    a_push_auto: assert property (
        @(posedge aclk) disable iff (!aresetn) push |-> !$past(man_busy)
    );

endmodule

`default_nettype wire

//--- hdl/ads124x_spi_framer.sv
// ========================================
// ADS124x SPI word framer
// Splits a 1 to 4 byte request into byte transfers
// and gathers the received bytes into one word
// ========================================
`timescale 1ns/10ps
`default_nettype none

module ads124x_spi_framer import ads124x_pkg::*; (
    input  wire           aclk,
    input  wire           aresetn,
    input  wire           req_valid,
    input  wire [31:0]    req_data,
    input  wire spi_len_t req_len,
    input  wire           byte_done,
    input  wire [7:0]     rx_byte,
    output wire           req_ready,
    output logic          done,
    output ads_word_u     rx_word,
    output logic          cs_n,
    output logic          byte_start,
    output logic [7:0]    tx_byte
);

    logic [31:0] tx_data;
    spi_len_t    bytes_left;
    spi_len_t    next_idx;
    logic        accept;
    logic        byte_in;

    // Chip select high means no frame in progress
    assign req_ready = cs_n;
    assign accept    = req_valid && cs_n;
    assign byte_in   = !cs_n && byte_done;
    assign next_idx  = bytes_left - 2'd1;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cs_n       <= 1'b1;
            byte_start <= 1'b0;
            done       <= 1'b0;
            bytes_left <= '0;
        end else begin
            byte_start <= 1'b0;
            done       <= 1'b0;
            if (accept) begin
                cs_n       <= 1'b0;
                byte_start <= 1'b1;
                bytes_left <= req_len;
            end else if (byte_in) begin
                if (bytes_left == 2'd0) begin
                    cs_n <= 1'b1;
                    done <= 1'b1;
                end else begin
                    bytes_left <= next_idx;
                    byte_start <= 1'b1;
                end
            end
        end
    end

    // MSB first, received bytes enter at the low end
    always_ff @(posedge aclk) begin
        if (accept) begin
            tx_data     <= req_data;
            tx_byte     <= req_data[8*req_len +: 8];
            rx_word.raw <= '0;
        end else if (byte_in) begin
            tx_byte     <= tx_data[8*next_idx +: 8];
            rx_word.raw <= {rx_word.raw[23:0], rx_byte};
        end
    end

    a_start_in_frame: assert property (
        @(posedge aclk) disable iff (!aresetn) byte_start |-> !cs_n
    );

endmodule

`default_nettype wire

//--- hdl/ads124x_spi_master.sv
// ========================================
// ADS124x SPI byte engine
// Mode 1 transfer of one byte with divided SCLK
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module ads124x_spi_master (
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        byte_start,
    input  wire [7:0]  tx_byte,
    input  wire        miso,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       sclk,
    output logic       mosi
);

    localparam int DIV_W = $clog2(`ADS_SPI_DIV + 1);

    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       edge_cnt;
    logic [7:0]       tx_sr;
    logic             half_tick;

    // One SCLK half period elapsed
    assign half_tick = active && div_cnt == DIV_W'(`ADS_SPI_DIV - 1);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            active    <= 1'b0;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (byte_start) begin
                active   <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
            end else if (active) begin
                div_cnt <= half_tick ? '0 : div_cnt + DIV_W'(1);
                if (half_tick) begin
                    sclk     <= !sclk;
                    edge_cnt <= edge_cnt + 4'd1;
                    // Rising edge drives MOSI, sixteenth edge ends the byte
                    if (!sclk) begin
                        mosi <= tx_sr[7];
                    end else if (edge_cnt == 4'd15) begin
                        active    <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (byte_start) begin
            tx_sr <= tx_byte;
        end else if (half_tick && !sclk) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
        // MISO sampled on the falling edge
        if (half_tick && sclk) begin
            rx_byte <= {rx_byte[6:0], miso};
        end
    end

    a_start_idle: assert property (
        @(posedge aclk) disable iff (!aresetn) byte_start |-> !active
    );

endmodule

`default_nettype wire

//--- hdl/ads124x_sample_fifo.sv
// ========================================
// ADS124x sample FIFO
// Circular buffer with level and sticky overflow
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module ads124x_sample_fifo import ads124x_pkg::*; (
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            push,
    input  wire ads_word_u push_word,
    input  wire            pop,
    input  wire            ovf_clear,
    output ads_word_u      head,
    output wire            empty,
    output logic [3:0]     level,
    output logic           overflow
);

    localparam int DEPTH = `ADS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ads_word_u        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty   = level == 4'd0;
    assign full    = level == 4'(DEPTH);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            level <= level + 4'(do_push) - 4'(do_pop);
            // Sample lost when full
            if (push && full) begin
                overflow <= 1'b1;
            end else if (ovf_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    a_no_empty_pop: assert property (
        @(posedge aclk) disable iff (!aresetn) pop |-> !empty
    );

endmodule

`default_nettype wire

//--- hdl/ads124x_top.sv
// ========================================
// ADS124x ADC controller top level
// APB registers, sequencer, SPI and sample FIFO
// ========================================
`timescale 1ns/10ps
`default_nettype none

module ads124x_top import ads124x_pkg::*; (
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire [4:0]  paddr,
    input  wire [31:0] pwdata,
    output wire [31:0] prdata,
    output wire        pready,
    output wire        pslverr,
    input  wire        miso,
    input  wire        drdy,
    input  wire        pps,
    output wire        sclk,
    output wire        mosi,
    output wire        cs_n,
    output wire        start,
    output wire        ads_reset_n
);

    wire            auto_mode;
    wire            start_pin;
    wire            reset_pin_n;
    wire [31:0]     period;
    wire [31:0]     tx_word;
    wire            cmd_go;
    wire spi_len_t  cmd_len;
    wire            ovf_clear;
    wire            pop;
    wire            busy;
    wire            rx_done;
    wire            drdy_level;
    wire            overflow;
    wire [3:0]      fifo_level;
    wire ads_word_u fifo_head;
    wire            fifo_empty;
    wire            req_valid;
    wire            req_ready;
    wire [31:0]     req_data;
    wire spi_len_t  req_len;
    wire            done;
    wire ads_word_u rx_word;
    wire            push;
    wire ads_word_u push_word;
    wire            byte_start;
    wire            byte_done;
    wire [7:0]      tx_byte;
    wire [7:0]      rx_byte;

    ads124x_apb_regs u_regs (
        .aclk, .aresetn, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .auto_mode, .start_pin, .reset_pin_n, .period, .tx_word,
        .cmd_go, .cmd_len, .ovf_clear, .pop,
        .busy, .rx_done, .rx_word, .drdy_level, .overflow,
        .fifo_level, .fifo_head, .fifo_empty
    );

    ads124x_seq_ctrl u_seq (
        .aclk, .aresetn, .auto_mode, .start_pin, .reset_pin_n,
        .period, .tx_word, .cmd_go, .cmd_len, .drdy, .pps,
        .req_ready, .done, .rx_word,
        .start, .ads_reset_n, .drdy_level, .busy,
        .req_valid, .req_data, .req_len, .rx_done, .push, .push_word
    );

    ads124x_spi_framer u_framer (
        .aclk, .aresetn, .req_valid, .req_data, .req_len,
        .byte_done, .rx_byte,
        .req_ready, .done, .rx_word, .cs_n, .byte_start, .tx_byte
    );

    ads124x_spi_master u_spi (
        .aclk, .aresetn, .byte_start, .tx_byte, .miso,
        .byte_done, .rx_byte, .sclk, .mosi
    );

    ads124x_sample_fifo u_fifo (
        .aclk, .aresetn, .push, .push_word, .pop, .ovf_clear,
        .head     (fifo_head),
        .empty    (fifo_empty),
        .level    (fifo_level),
        .overflow (overflow)
    );

endmodule

`default_nettype wire

//--- sim/ads124x_adc_model.sv
// ========================================
// ADS124x behavioral ADC
// MUX0 register, conversion timer, DRDY and
// SPI echo or conversion data on MISO
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module ads124x_adc_model (
    input  wire  sclk,
    input  wire  mosi,
    input  wire  cs_n,
    output logic miso,
    output logic drdy
);

    logic [7:0]  mux0 = 8'h00;
    logic [15:0] conv_count = 16'd0;
    logic [7:0]  frame [4];
    int          nbytes = 0;
    int          bitpos = 0;
    logic [7:0]  rx_sr = 8'h00;
    logic [7:0]  tx_sr = 8'h00;
    logic [23:0] conv_data = 24'h0;
    logic        conv_frame = 1'b0;
    event        mux_written;

    initial begin
        miso = 1'b0;
        drdy = 1'b1;
    end

    // Frame start, conversion data only while DRDY is low
    always @(negedge cs_n) begin
        nbytes     = 0;
        bitpos     = 0;
        conv_frame = !drdy;
        conv_data  = {mux0, conv_count};
    end

    // Next MISO bit on the SCLK rising edge
    always @(posedge sclk) begin
        if (cs_n === 1'b0) begin
            if (bitpos == 0) begin
                if (conv_frame) begin
                    tx_sr = (nbytes < 3) ? conv_data[8*(2-nbytes) +: 8] : 8'h00;
                end else begin
                    tx_sr = (nbytes == 0) ? 8'h00 : frame[nbytes-1];
                end
            end
            miso  = tx_sr[7];
            tx_sr = {tx_sr[6:0], 1'b0};
        end
    end

    // MOSI sampled on the falling edge
    always @(negedge sclk) begin
        if (cs_n === 1'b0) begin
            rx_sr  = {rx_sr[6:0], mosi};
            bitpos = bitpos + 1;
            if (bitpos == 8) begin
                if (nbytes < 4) begin
                    frame[nbytes] = rx_sr;
                end
                nbytes = nbytes + 1;
                bitpos = 0;
            end
        end
    end

    // Frame end
    always @(posedge cs_n) begin
        if (nbytes == 3 && {frame[0], frame[1]} == `ADS_WREG_MUX0) begin
            mux0 = frame[2];
            -> mux_written;
        end
        if (conv_frame && nbytes > 0 && frame[0] == `ADS_NOOP) begin
            conv_count = conv_count + 16'd1;
            drdy       = 1'b1;
        end
    end

    // 200 ns conversion, kept off the clock edges
    always @(mux_written) begin
        #201;
        drdy = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tb_ads124x.sv
// ========================================
// ADS124x controller testbench
// Directed APB tests against the ADC model
// ========================================
`timescale 1ns/10ps
`default_nettype none
`include "ads124x_macros.svh"

module tb_ads124x;

    localparam int CLK_NS    = 4;
    localparam int AUTO_PER  = 1200;
    localparam int BUDGET_NS = 400 + 12 * 800 + 400 + (AUTO_PER + 300) * CLK_NS
                             + (3 * AUTO_PER + 500) * CLK_NS + 400;

    logic        aclk;
    logic        aresetn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic        pps;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         sclk;
    wire         mosi;
    wire         miso;
    wire         cs_n;
    wire         start;
    wire         ads_reset_n;
    wire         drdy;
    logic        last_err;
    integer      seed;
    int          conv_reads;

    ads124x_top dut (
        .aclk, .aresetn, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .miso, .drdy, .pps,
        .sclk, .mosi, .cs_n, .start, .ads_reset_n
    );

    ads124x_adc_model adc (.sclk, .mosi, .cs_n, .miso, .drdy);

    always #(CLK_NS / 2) aclk = ~aclk;

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s (at %0d ns)", what, $time);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        #1;
        last_err = pslverr;
        check_eq("pready", pready, 1'b1);
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge aclk);
        penable = 1'b1;
        #1;
        data     = prdata;
        last_err = pslverr;
        check_eq("pready", pready, 1'b1);
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
                               input int max_polls, input string what);
        logic [31:0] st;
        int          n;
        n = 0;
        apb_read(`ADS_REG_STATUS, st);
        while ((st & mask) != want && n < max_polls) begin
            apb_read(`ADS_REG_STATUS, st);
            n++;
        end
        check_true((st & mask) == want, what);
    endtask

    // Each MISO byte repeats the previous MOSI byte, the first is zero
    function automatic logic [31:0] echo_word(input logic [31:0] tx, input int nbytes);
        logic [31:0] rx;
        logic [7:0]  prev;
        int          k;
        rx   = '0;
        prev = 8'h00;
        for (k = nbytes - 1; k >= 0; k--) begin
            rx   = {rx[23:0], prev};
            prev = tx[8*k +: 8];
        end
        return rx;
    endfunction

    function automatic logic [31:0] sample_word(input int tag, input int count);
        logic [7:0] mux;
        case (tag)
            0:       mux = `ADS_MUX_CH0;
            1:       mux = `ADS_MUX_CH1;
            default: mux = `ADS_MUX_CH2;
        endcase
        return {8'(tag), mux, 16'(count)};
    endfunction

    task automatic test_reset_regs();
        logic [31:0] rd;
        logic [31:0] wd;
        // ADC pins after reset
        check_eq("cs_n", cs_n, 1'b1);
        check_eq("sclk", sclk, 1'b0);
        check_eq("start", start, 1'b0);
        check_eq("ads_reset_n", ads_reset_n, 1'b1);
        // DRDY idles high in the model
        apb_read(`ADS_REG_STATUS, rd);
        check_eq("STATUS", rd, 32'h04);
        apb_read(`ADS_REG_CTRL, rd);
        check_eq("CTRL", rd, 32'h04);
        // Long period keeps the slot ticks away
        apb_write(`ADS_REG_PERIOD, 32'h7654_3210);
        apb_read(`ADS_REG_PERIOD, rd);
        check_eq("PERIOD", rd, 32'h7654_3210);
        wd = $random(seed);
        apb_write(`ADS_REG_TXDATA, wd);
        apb_read(`ADS_REG_TXDATA, rd);
        check_eq("TXDATA", rd, wd);
    endtask

    task automatic test_manual();
        logic [31:0] tx;
        logic [31:0] rd;
        int          len;
        int          rep;
        for (len = 1; len <= 4; len++) begin
            for (rep = 0; rep < 3; rep++) begin
                tx = $random(seed);
                // Not a MUX0 write
                if (len == 3 && tx[23:16] == 8'h40) begin
                    tx[16] = 1'b1;
                end
                apb_write(`ADS_REG_TXDATA, tx);
                apb_write(`ADS_REG_CMD, 32'(len - 1));
                apb_read(`ADS_REG_STATUS, rd);
                check_eq("STATUS.rx_valid_busy", rd[1:0], 2'b01);
                poll_status(32'h1, 32'h0, 200, "busy stayed high after a manual transfer");
                apb_read(`ADS_REG_RXDATA, rd);
                check_eq("RXDATA", rd, echo_word(tx, len));
                apb_read(`ADS_REG_STATUS, rd);
                check_eq("STATUS.rx_valid", rd[1], 1'b1);
            end
        end
    endtask

    task automatic test_pins();
        apb_write(`ADS_REG_CTRL, 32'h2);
        check_eq("start", start, 1'b1);
        check_eq("ads_reset_n", ads_reset_n, 1'b0);
        apb_write(`ADS_REG_CTRL, 32'h4);
        check_eq("start", start, 1'b0);
        check_eq("ads_reset_n", ads_reset_n, 1'b1);
        apb_write(`ADS_REG_CTRL, 32'h1);
        check_eq("start", start, 1'b1);
        check_eq("ads_reset_n", ads_reset_n, 1'b1);
        apb_write(`ADS_REG_CTRL, 32'h4);
    endtask

    task automatic test_auto();
        logic [31:0] rd;
        int          k;
        // Period counter held while pps is high
        @(negedge aclk);
        pps = 1'b1;
        apb_write(`ADS_REG_PERIOD, 32'(AUTO_PER));
        apb_write(`ADS_REG_CTRL, 32'h5);
        @(negedge aclk);
        pps = 1'b0;
        poll_status(32'hF0, 32'h30, AUTO_PER / 2, "three auto samples missing after one period");
        for (k = 0; k < 3; k++) begin
            apb_read(`ADS_REG_FIFO, rd);
            check_eq("pslverr", last_err, 1'b0);
            check_eq("FIFO", rd, sample_word(k, conv_reads));
            conv_reads++;
        end
        apb_write(`ADS_REG_CTRL, 32'h4);
    endtask

    task automatic test_fifo_limits();
        logic [31:0] rd;
        int          k;
        @(negedge aclk);
        pps = 1'b1;
        apb_write(`ADS_REG_CTRL, 32'h5);
        @(negedge aclk);
        pps = 1'b0;
        poll_status(32'h08, 32'h08, 4 * AUTO_PER / 3, "overflow never set after three periods");
        apb_write(`ADS_REG_CTRL, 32'h4);
        apb_read(`ADS_REG_STATUS, rd);
        check_eq("STATUS.level", rd[7:4], 4'd8);
        apb_write(`ADS_REG_STATUS, 32'h8);
        apb_read(`ADS_REG_STATUS, rd);
        check_eq("STATUS.overflow", rd[3], 1'b0);
        for (k = 0; k < 8; k++) begin
            apb_read(`ADS_REG_FIFO, rd);
            check_eq("pslverr", last_err, 1'b0);
            check_eq("FIFO", rd, sample_word(k % 3, conv_reads));
            conv_reads++;
        end
        apb_read(`ADS_REG_FIFO, rd);
        check_eq("pslverr", last_err, 1'b1);
    endtask

    task automatic test_bad_access();
        logic [31:0] rd;
        apb_read(5'h1C, rd);
        check_eq("pslverr", last_err, 1'b1);
        apb_write(5'h1C, 32'h1234_5678);
        check_eq("pslverr", last_err, 1'b1);
        @(negedge aclk);
        pps = 1'b1;
        apb_write(`ADS_REG_CTRL, 32'h5);
        apb_write(`ADS_REG_CMD, 32'h3);
        apb_read(`ADS_REG_STATUS, rd);
        check_eq("STATUS.busy", rd[0], 1'b0);
        check_eq("cs_n", cs_n, 1'b1);
        apb_write(`ADS_REG_CTRL, 32'h4);
        @(negedge aclk);
        pps = 1'b0;
    endtask

    initial begin
        aclk       = 1'b0;
        aresetn    = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pps        = 1'b0;
        last_err   = 1'b0;
        seed       = 32'hc918151e;
        conv_reads = 0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        test_reset_regs();
        test_manual();
        test_pins();
        test_auto();
        test_fifo_limits();
        test_bad_access();
        $display("All tests passed!");
        $finish;
    end

    // Watchdog
    initial begin
        #(BUDGET_NS);
        $display("timeout: tests still running after %0d ns", BUDGET_NS);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hdl/ads124x_pkg.sv
hdl/ads124x_apb_regs.sv
hdl/ads124x_seq_ctrl.sv
hdl/ads124x_spi_framer.sv
hdl/ads124x_spi_master.sv
hdl/ads124x_sample_fifo.sv
hdl/ads124x_top.sv
sim/ads124x_adc_model.sv
sim/tb_ads124x.sv
